// ==== mister_loader.f ====
+incdir+hdl
hdl/loader_pkg.sv
hdl/loader_timer.sv
hdl/prog_packer.sv
hdl/dip_regs.sv
hdl/loader_fsm.sv
hdl/mister_loader.sv
testbench/tb_mister_loader.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the loader testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -j 0 \
    --top-module tb_mister_loader \
    -f mister_loader.f \
    --Mdir obj_dir

./obj_dir/Vtb_mister_loader > sim.log 2>&1
cat sim.log

if grep -q "TESTBENCH FAILED" sim.log; then
    echo "simulation reported failure, see sim.log"
    exit 1
fi

echo "simulation finished without failure"
exit 0

// ==== testbench/tb_mister_loader.sv ====
/*
 * Testbench for the ROM download front end
 * Random host downloads checked against a byte model and an SDRAM loader responder
 */
`include "loader_params.svh"

module tb_mister_loader;

    localparam int N_DOWNLOADS = 12;
    localparam int WR_PER_DL   = 16;
    localparam int ROM_BYTES   = 256;
    localparam int WATCHDOG_T  =
        (N_DOWNLOADS * WR_PER_DL * 10 + N_DOWNLOADS * (`TAIL_CYCLES + 10)) * 8;

    logic                  clk_rom;
    logic                  arst_n;
    logic                  hps_download;
    logic                  hps_wr;
    loader_pkg::host_wr_t  hps_bus;
    logic                  hps_wait;
    loader_pkg::prog_req_t prog;
    logic                  prog_we;
    logic                  prog_rdy;
    logic [31:0]           dipsw;
    logic                  downloading;

    // Reference ROM image and the image seen by the SDRAM loader
    logic [7:0]            rom_model [ROM_BYTES];
    logic [7:0]            rom_image [ROM_BYTES];
    logic [31:0]           dip_model;
    loader_pkg::prog_req_t exp_q [$];
    int                    n_errors = 0;
    int                    n_rom    = 0;
    int                    n_dip    = 0;
    int                    n_skip   = 0;

    mister_loader u_dut (
        .clk_rom      ( clk_rom      ),
        .arst_n       ( arst_n       ),
        .hps_download ( hps_download ),
        .hps_wr       ( hps_wr       ),
        .hps_bus      ( hps_bus      ),
        .hps_wait     ( hps_wait     ),
        .prog         ( prog         ),
        .prog_we      ( prog_we      ),
        .prog_rdy     ( prog_rdy     ),
        .dipsw        ( dipsw        ),
        .downloading  ( downloading  )
    );

    initial begin
        clk_rom = 1'b0;
        forever begin
            #4;
            clk_rom = ~clk_rom;
        end
    end

    // Inputs change 1 unit after the edge
    task automatic step();
        @(posedge clk_rom);
        #1;
    endtask

    task automatic value_error(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        n_errors++;
        $display("error: %s got %h expected %h at %0t", name, got, exp, $time);
    endtask

    task automatic plain_error(input string msg);
        n_errors++;
        $display("failure: %s at %0t", msg, $time);
    endtask

    // One host byte write with a random index and address
    task automatic host_write();
        int                    pick;
        int                    byte_off;
        int                    lane;
        logic                  is_rom;
        loader_pkg::host_wr_t  wr;
        loader_pkg::prog_req_t req;
        pick = $urandom_range(0, 9);
        if (pick < 6) begin
            wr.index = `LOAD_IDX_ROM;
            wr.addr  = `LOAD_AW'($urandom_range(0, `HDR_LEN + ROM_BYTES - 1));
        end else if (pick < 9) begin
            wr.index = `LOAD_IDX_DIP;
            wr.addr  = `LOAD_AW'($urandom_range(0, 15));
        end else begin
            wr.index = 8'($urandom_range(1, 253));
            wr.addr  = `LOAD_AW'($urandom_range(0, 4095));
        end
        wr.data = 8'($urandom_range(0, 255));
        is_rom  = (wr.index == `LOAD_IDX_ROM) && (int'(wr.addr) >= `HDR_LEN);
        if (is_rom) begin
            // Word address past the header and the byte in both lanes
            byte_off   = int'(wr.addr) - `HDR_LEN;
            req.addr   = `PROG_AW'(byte_off / 2);
            req.data   = {wr.data, wr.data};
            req.mask   = wr.addr[0] ? 2'b01 : 2'b10;
            exp_q.push_back(req);
            rom_model[byte_off] = wr.data;
            n_rom++;
        end else if (wr.index == `LOAD_IDX_DIP) begin
            lane = int'(wr.addr[1:0]);
            dip_model[lane*8 +: 8] = wr.data;
            n_dip++;
        end else begin
            n_skip++;
        end
        hps_bus = wr;
        hps_wr  = 1'b1;
        step();
        hps_wr  = 1'b0;
        if (prog_we !== is_rom) value_error("prog_we", 64'(prog_we), 64'(is_rom));
        if (hps_wait !== is_rom) value_error("hps_wait", 64'(hps_wait), 64'(is_rom));
        if (dipsw !== dip_model) value_error("dipsw", 64'(dipsw), 64'(dip_model));
        while (hps_wait) begin
            step();
        end
    endtask

    task automatic run_download();
        hps_download = 1'b1;
        // No lead time puts a write on the first cycle of the download
        repeat ($urandom_range(0, 3)) step();
        repeat (WR_PER_DL) begin
            host_write();
            repeat ($urandom_range(0, 2)) step();
        end
        hps_download = 1'b0;
        // Short gaps restart the download inside the tail
        repeat ($urandom_range(1, 20)) step();
    endtask

    initial begin : main_seq
        int i;
        void'($urandom(32'h8f44));
        arst_n       = 1'b0;
        hps_download = 1'b0;
        hps_wr       = 1'b0;
        hps_bus      = '0;
        dip_model    = `DIP_DEFAULT;
        for (i = 0; i < ROM_BYTES; i++) begin
            rom_model[i] = 8'(i) ^ 8'ha5;
            rom_image[i] = 8'(i) ^ 8'ha5;
        end
        repeat (3) @(posedge clk_rom);
        #1;
        arst_n = 1'b1;
        if (prog_we !== 1'b0) value_error("prog_we", 64'(prog_we), 64'h0);
        if (hps_wait !== 1'b0) value_error("hps_wait", 64'(hps_wait), 64'h0);
        if (downloading !== 1'b0) value_error("downloading", 64'(downloading), 64'h0);
        if (dipsw !== `DIP_DEFAULT) value_error("dipsw", 64'(dipsw), 64'(`DIP_DEFAULT));
        repeat (N_DOWNLOADS) run_download();
        repeat (`TAIL_CYCLES + 2) step();
        if (downloading !== 1'b0) value_error("downloading", 64'(downloading), 64'h0);
        if (exp_q.size() != 0) begin
            plain_error("ROM writes never reached the SDRAM loader");
        end
        for (i = 0; i < ROM_BYTES; i++) begin
            if (rom_image[i] !== rom_model[i]) begin
                value_error($sformatf("rom byte %0d", i), 64'(rom_image[i]), 64'(rom_model[i]));
            end
        end
        $display("rom writes %0d, dip writes %0d, ignored writes %0d, errors %0d",
                 n_rom, n_dip, n_skip, n_errors);
        if (n_errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

    // SDRAM loader that accepts each word after 0 to 4 cycles
    initial begin : sdram_responder
        int                    delay;
        int                    byte_idx;
        loader_pkg::prog_req_t held;
        loader_pkg::prog_req_t want;
        prog_rdy = 1'b0;
        forever begin
            step();
            if (prog_we) begin
                held = prog;
                if (exp_q.size() == 0) begin
                    plain_error("prog_we raised with no ROM write pending");
                    want = prog;
                end else begin
                    want = exp_q.pop_front();
                end
                delay = $urandom_range(0, 4);
                repeat (delay) begin
                    step();
                    if (prog_we !== 1'b1) value_error("prog_we", 64'(prog_we), 64'h1);
                    if (hps_wait !== 1'b1) value_error("hps_wait", 64'(hps_wait), 64'h1);
                    if (prog !== held) value_error("prog", 64'(prog), 64'(held));
                end
                if (prog !== want) value_error("prog", 64'(prog), 64'(want));
                // Mask bit 0 set means the upper byte is the one written
                byte_idx = int'(prog.addr) * 2 + ((prog.mask == 2'b01) ? 1 : 0);
                if (byte_idx < ROM_BYTES) begin
                    rom_image[byte_idx] = (prog.mask == 2'b01) ? prog.data[15:8] : prog.data[7:0];
                end else begin
                    plain_error("prog address outside the ROM image");
                end
                prog_rdy = 1'b1;
                step();
                prog_rdy = 1'b0;
                if (prog_we !== 1'b0) value_error("prog_we", 64'(prog_we), 64'h0);
                if (hps_wait !== 1'b0) value_error("hps_wait", 64'(hps_wait), 64'h0);
            end
        end
    end

    // Download flag held for the tail after the host drops
    initial begin : download_monitor
        int tail_left;
        tail_left = 0;
        @(posedge arst_n);
        forever begin
            @(posedge clk_rom);
            if (hps_download) begin
                tail_left = `TAIL_CYCLES + 1;
            end else if (tail_left != 0) begin
                tail_left--;
            end
            #1;
            if (downloading !== (tail_left != 0)) begin
                value_error("downloading", 64'(downloading), 64'(tail_left != 0));
            end
        end
    end

    initial begin : watchdog
        #(WATCHDOG_T);
        $display("timeout: the run did not finish within %0d time units", WATCHDOG_T);
        $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

// ==== hdl/mister_loader.sv ====
/*
 * MiSTer ROM download front end
 * Feeds the SDRAM loader and the DIP word from HPS writes
 */
module mister_loader (
    input  logic                  clk_rom,
    input  logic                  arst_n,
    // HPS download port
    input  logic                  hps_download,
    input  logic                  hps_wr,
    input  loader_pkg::host_wr_t  hps_bus,
    output logic                  hps_wait,
    // SDRAM loader
    output loader_pkg::prog_req_t prog,
    output logic                  prog_we,
    input  logic                  prog_rdy,
    // Control word and game reset hold
    output logic [31:0]           dipsw,
    output logic                  downloading
);

    logic rom_load;
    logic dip_load;
    logic tail_start;
    logic tail_done;

    loader_fsm u_fsm (
        .clk_rom      ( clk_rom      ),
        .arst_n       ( arst_n       ),
        .hps_download ( hps_download ),
        .hps_wr       ( hps_wr       ),
        .hps_bus      ( hps_bus      ),
        .prog_rdy     ( prog_rdy     ),
        .tail_done    ( tail_done    ),
        .rom_load     ( rom_load     ),
        .dip_load     ( dip_load     ),
        .prog_we      ( prog_we      ),
        .hps_wait     ( hps_wait     ),
        .tail_start   ( tail_start   ),
        .downloading  ( downloading  )
    );

    loader_timer u_timer (
        .clk_rom      ( clk_rom      ),
        .arst_n       ( arst_n       ),
        .tail_start   ( tail_start   ),
        .tail_done    ( tail_done    )
    );

    prog_packer u_packer (
        .clk_rom      ( clk_rom      ),
        .arst_n       ( arst_n       ),
        .rom_load     ( rom_load     ),
        .hps_bus      ( hps_bus      ),
        .prog         ( prog         )
    );

    dip_regs u_dip (
        .clk_rom      ( clk_rom      ),
        .arst_n       ( arst_n       ),
        .dip_load     ( dip_load     ),
        .hps_bus      ( hps_bus      ),
        .dipsw        ( dipsw        )
    );

endmodule

// ==== hdl/loader_fsm.sv ====
/*
 * Loader control FSM
 * Sorts host writes by index and paces them against the SDRAM loader
 */
`include "loader_params.svh"

module loader_fsm (
    input  logic                 clk_rom,
    input  logic                 arst_n,
    input  logic                 hps_download,
    input  logic                 hps_wr,
    input  loader_pkg::host_wr_t hps_bus,
    input  logic                 prog_rdy,
    input  logic                 tail_done,
    output logic                 rom_load,
    output logic                 dip_load,
    output logic                 prog_we,
    output logic                 hps_wait,
    output logic                 tail_start,
    output logic                 downloading
);

    loader_pkg::load_state_e state, state_nxt;
    loader_pkg::load_kind_e  load_kind;
    logic                    accept;

    // A write can land on the very first cycle of hps_download
    assign accept = hps_wr && hps_download && (state != loader_pkg::WAIT_RDY);

    always_comb begin
        load_kind = loader_pkg::KIND_NONE;
        if (hps_bus.index == `LOAD_IDX_ROM) begin
            // Header bytes are dropped
            if (hps_bus.addr >= `LOAD_AW'(`HDR_LEN)) begin
                load_kind = loader_pkg::KIND_ROM;
            end
        end else if (hps_bus.index == `LOAD_IDX_DIP) begin
            load_kind = loader_pkg::KIND_DIP;
        end
    end

    assign rom_load = accept && (load_kind == loader_pkg::KIND_ROM);
    assign dip_load = accept && (load_kind == loader_pkg::KIND_DIP);

    always_comb begin
        state_nxt = state;
        case (state)
            loader_pkg::IDLE, loader_pkg::TAIL: begin
                if (rom_load) begin
                    state_nxt = loader_pkg::WAIT_RDY;
                end else if (hps_download) begin
                    state_nxt = loader_pkg::ACTIVE;
                end else if (state == loader_pkg::TAIL && tail_done) begin
                    state_nxt = loader_pkg::IDLE;
                end
            end
            loader_pkg::ACTIVE: begin
                if (rom_load) begin
                    state_nxt = loader_pkg::WAIT_RDY;
                end else if (!hps_download) begin
                    state_nxt = loader_pkg::TAIL;
                end
            end
            loader_pkg::WAIT_RDY: begin
                if (prog_rdy) begin
                    state_nxt = loader_pkg::ACTIVE;
                end
            end
            default: state_nxt = loader_pkg::IDLE;
        endcase
    end

    always_ff @(posedge clk_rom or negedge arst_n) begin
        if (!arst_n) begin
            state <= loader_pkg::IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // Host stays held off while the word is pending
    assign prog_we     = (state == loader_pkg::WAIT_RDY);
    assign hps_wait    = (state == loader_pkg::WAIT_RDY);
    assign tail_start  = (state == loader_pkg::ACTIVE) && !hps_download;
    assign downloading = (state != loader_pkg::IDLE);

endmodule

// ==== hdl/dip_regs.sv ====
/*
 * DIP switch word
 * Built byte by byte from the DIP download index
 */
`include "loader_params.svh"

module dip_regs (
    input  logic                 clk_rom,
    input  logic                 arst_n,
    input  logic                 dip_load,
    input  loader_pkg::host_wr_t hps_bus,
    output logic [31:0]          dipsw
);

    always_ff @(posedge clk_rom or negedge arst_n) begin
        if (!arst_n) begin
            dipsw <= `DIP_DEFAULT;
        end else if (dip_load) begin
            // Byte lane from the two low address bits
            dipsw[hps_bus.addr[1:0]*8 +: 8] <= hps_bus.data;
        end
    end

endmodule

// ==== hdl/prog_packer.sv ====
/*
 * Programming request register
 * Turns a ROM byte into an SDRAM word write with byte mask
 */
`include "loader_params.svh"

module prog_packer (
    input  logic                  clk_rom,
    input  logic                  arst_n,
    input  logic                  rom_load,
    input  loader_pkg::host_wr_t  hps_bus,
    output loader_pkg::prog_req_t prog
);

    logic [`LOAD_AW-1:0] rom_offset;

    // Byte offset past the header
    assign rom_offset = hps_bus.addr - `LOAD_AW'(`HDR_LEN);

    always_ff @(posedge clk_rom or negedge arst_n) begin
        if (!arst_n) begin
            prog <= '0;
        end else if (rom_load) begin
            prog.addr <= rom_offset[`PROG_AW:1];
            prog.data <= {hps_bus.data, hps_bus.data};
            // Odd bytes go to the upper lane, so the low lane is masked
            prog.mask <= {~hps_bus.addr[0], hps_bus.addr[0]};
        end
    end

endmodule

// ==== hdl/loader_timer.sv ====
/*
 * Download tail timer
 * Pulses tail_done a fixed number of cycles after tail_start
 */
`include "loader_params.svh"

module loader_timer (
    input  logic clk_rom,
    input  logic arst_n,
    input  logic tail_start,
    output logic tail_done
);

    logic [`TAIL_W-1:0] cnt;

    always_ff @(posedge clk_rom or negedge arst_n) begin
        if (!arst_n) begin
            cnt <= '0;
        end else if (tail_start) begin
            cnt <= `TAIL_W'(`TAIL_CYCLES);
        end else if (cnt != '0) begin
            // Stops at zero
            cnt <= cnt - 1'b1;
        end
    end

    // Last counting cycle
    assign tail_done = (cnt == `TAIL_W'(1));

endmodule

// ==== hdl/loader_pkg.sv ====
/*
 * ROM loader types
 * FSM states, write kinds and the host and programming buses
 */
`include "loader_params.svh"

package loader_pkg;

    typedef enum logic [1:0] {
        IDLE     = 2'd0,
        ACTIVE   = 2'd1,
        WAIT_RDY = 2'd2,
        TAIL     = 2'd3
    } load_state_e;

    typedef enum logic [1:0] {
        KIND_NONE = 2'd0,
        KIND_ROM  = 2'd1,
        KIND_DIP  = 2'd2
    } load_kind_e;

    // One byte write from the HPS
    typedef struct packed {
        logic [`LOAD_AW-1:0] addr;
        logic [7:0]          data;
        logic [7:0]          index;
    } host_wr_t;

    // Word write to the SDRAM loader where a high mask bit skips its byte
    typedef struct packed {
        logic [`PROG_AW-1:0] addr;
        logic [15:0]         data;
        logic [1:0]          mask;
    } prog_req_t;

endpackage

// ==== hdl/loader_params.svh ====
/*
 * ROM loader parameters
 * Widths, load indices and timing constants of the download path
 */
`ifndef LOADER_PARAMS_SVH
`define LOADER_PARAMS_SVH

// Host byte address and SDRAM word address
`define LOAD_AW      27
`define PROG_AW      23

// ioctl_index values
`define LOAD_IDX_ROM 8'd0
`define LOAD_IDX_DIP 8'd254

// ROM header bytes skipped before programming starts
`define HDR_LEN      32

// Game held in reset this long after the last write
`define TAIL_CYCLES  16
`define TAIL_W       5

// All switches off
`define DIP_DEFAULT  32'hffff_ffff

`endif
